/* vlog.f */
hdl/regmap_pkg.sv
hdl/axil_write_channel.sv
hdl/axil_read_channel.sv
hdl/regbus_arbiter.sv
hdl/receiver_regmap.sv
hdl/receiver_regmap_top.sv
dv/tb_receiver_regmap.sv

/* dv/tb_receiver_regmap.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_receiver_regmap;

    import regmap_pkg::*;

    localparam logic [31:0] DUT_ID = 32'h0000_00A5;
    // cycles any single wait may take
    localparam int TIMEOUT = 50;
    // selectors for the wait loop
    localparam int SIG_AWREADY = 0;
    localparam int SIG_BVALID = 1;
    localparam int SIG_ARREADY = 2;
    localparam int SIG_RVALID = 3;

    logic clk = 1'b0;
    logic reset_n;
    logic [10:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [10:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [1:0] fs_state;
    logic [31:0] rx_signal;
    logic [31:0] rx_ctrl;

    int errors = 0;
    integer seed = 32'h15ef_1a0e;
    // expected contents of the writable registers
    logic [31:0] scratch_exp = 32'd0;
    logic [31:0] rx_ctrl_exp = 32'd0;

    // 40 ns period
    always #20 clk = ~clk;

    receiver_regmap_top #(
        .ID(DUT_ID),
        .ADDRESS_WIDTH(11)
    ) i_dut (
        .clk_i(clk),
        .reset_ni(reset_n),
        .s_axi_awaddr_i(awaddr),
        .s_axi_awvalid_i(awvalid),
        .s_axi_awready_o(awready),
        .s_axi_wdata_i(wdata),
        .s_axi_wstrb_i(wstrb),
        .s_axi_wvalid_i(wvalid),
        .s_axi_wready_o(wready),
        .s_axi_bresp_o(bresp),
        .s_axi_bvalid_o(bvalid),
        .s_axi_bready_i(bready),
        .s_axi_araddr_i(araddr),
        .s_axi_arvalid_i(arvalid),
        .s_axi_arready_o(arready),
        .s_axi_rdata_o(rdata),
        .s_axi_rresp_o(rresp),
        .s_axi_rvalid_o(rvalid),
        .s_axi_rready_i(rready),
        .fs_state_i(fs_state),
        .rx_signal_i(rx_signal),
        .rx_ctrl_o(rx_ctrl)
    );

    function automatic logic [10:0] byte_addr(input logic [8:0] index);
        return {index, 2'b00};
    endfunction

    // register map model
    function automatic logic [31:0] expected_value(input logic [8:0] index);
        case (index)
            REG_VERSION: return PCORE_VERSION;
            REG_ID: return DUT_ID;
            REG_SCRATCH: return scratch_exp;
            REG_SIGNATURE: return RX_SIGNATURE;
            REG_PATTERN: return RX_PATTERN;
            REG_FS_STATE: return {30'd0, fs_state};
            REG_RX_SIGNAL: return rx_signal;
            REG_RX_CTRL: return rx_ctrl_exp;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic flag_value(input int sel);
        case (sel)
            SIG_AWREADY: return awready;
            SIG_BVALID: return bvalid;
            SIG_ARREADY: return arready;
            default: return rvalid;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // sample on the falling edge until the flag is high
    task automatic wait_signal(input int sel, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!flag_value(sel) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!flag_value(sel)) begin
            errors++;
            $display("timeout: %s did not go high within %0d cycles", what, TIMEOUT);
        end
    endtask

    task automatic axil_write(input logic [8:0] index, input logic [31:0] data);
        @(posedge clk);
        awaddr <= byte_addr(index);
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        wait_signal(SIG_AWREADY, "awready");
        // wready pulses together with awready
        check_value("wready", {31'd0, wready}, 32'd1);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        wait_signal(SIG_BVALID, "bvalid");
        check_value("bresp", {30'd0, bresp}, 32'd0);
        if (index == REG_SCRATCH) begin
            scratch_exp = data;
        end else if (index == REG_RX_CTRL) begin
            rx_ctrl_exp = data;
        end
    endtask

    task automatic axil_read(input logic [8:0] index, output logic [31:0] data);
        @(posedge clk);
        araddr <= byte_addr(index);
        arvalid <= 1'b1;
        wait_signal(SIG_ARREADY, "arready");
        @(posedge clk);
        arvalid <= 1'b0;
        wait_signal(SIG_RVALID, "rvalid");
        data = rdata;
        check_value("rresp", {30'd0, rresp}, 32'd0);
    endtask

    task automatic check_read(input logic [8:0] index);
        logic [31:0] got;
        axil_read(index, got);
        check_value($sformatf("rdata[%0d]", index), got, expected_value(index));
    endtask

    task automatic check_idle_outputs();
        check_value("awready", {31'd0, awready}, 32'd0);
        check_value("wready", {31'd0, wready}, 32'd0);
        check_value("arready", {31'd0, arready}, 32'd0);
        check_value("bvalid", {31'd0, bvalid}, 32'd0);
        check_value("rvalid", {31'd0, rvalid}, 32'd0);
        check_value("rx_ctrl_o", rx_ctrl, 32'd0);
    endtask

    task automatic read_constant_registers();
        int i;
        for (i = 0; i < 5; i++) begin
            check_read(9'(i));
        end
    endtask

    task automatic read_status_registers();
        repeat (3) begin
            @(posedge clk);
            fs_state <= $random(seed);
            rx_signal <= $random(seed);
            check_read(REG_FS_STATE);
            check_read(REG_RX_SIGNAL);
        end
    endtask

    task automatic write_writable_registers();
        int i;
        repeat (4) begin
            axil_write(REG_SCRATCH, $random(seed));
            axil_write(REG_RX_CTRL, $random(seed));
            check_read(REG_SCRATCH);
            check_read(REG_RX_CTRL);
            @(negedge clk);
            check_value("rx_ctrl_o", rx_ctrl, rx_ctrl_exp);
        end
        // read-only and unmapped indices drop the write
        for (i = 0; i < 10; i++) begin
            if (i != 2 && i != 7 && i != 8) begin
                axil_write(9'(i), $random(seed));
            end
        end
        for (i = 0; i < 10; i++) begin
            check_read(9'(i));
        end
    endtask

    task automatic back_pressure();
        logic [31:0] second;
        logic [31:0] held;
        int i;
        second = $random(seed);
        @(posedge clk);
        bready <= 1'b0;
        axil_write(REG_SCRATCH, $random(seed));
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            if (!bvalid) begin
                errors++;
                $display("bvalid dropped while bready was low");
            end
        end
        // second write is offered while the response is still pending
        @(posedge clk);
        awaddr <= byte_addr(REG_SCRATCH);
        wdata <= second;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            if (awready || wready) begin
                errors++;
                $display("second write accepted before bready");
            end
        end
        @(posedge clk);
        bready <= 1'b1;
        wait_signal(SIG_AWREADY, "awready");
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        wait_signal(SIG_BVALID, "bvalid");
        scratch_exp = second;
        check_read(REG_SCRATCH);
        // read side, rdata must hold with rvalid
        @(posedge clk);
        rready <= 1'b0;
        axil_read(REG_SCRATCH, held);
        check_value("rdata", held, second);
        // second read is offered while rvalid is still pending
        @(posedge clk);
        araddr <= byte_addr(REG_SIGNATURE);
        arvalid <= 1'b1;
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            if (!rvalid) begin
                errors++;
                $display("rvalid dropped while rready was low");
            end
            if (arready) begin
                errors++;
                $display("second read accepted before rready");
            end
            check_value("rdata", rdata, held);
        end
        @(posedge clk);
        rready <= 1'b1;
        wait_signal(SIG_ARREADY, "arready");
        @(posedge clk);
        arvalid <= 1'b0;
        wait_signal(SIG_RVALID, "rvalid");
        check_value("rdata", rdata, RX_SIGNATURE);
    endtask

    task automatic concurrent_access();
        logic [31:0] data;
        logic [31:0] old_value;
        logic [31:0] got;
        logic [8:0] wr_index;
        logic [8:0] rd_index;
        int round;
        for (round = 0; round < 6; round++) begin
            wr_index = round[0] ? REG_RX_CTRL : REG_SCRATCH;
            // first rounds hit the written register, the last ones another one
            if (round < 4) begin
                rd_index = wr_index;
            end else begin
                rd_index = round[0] ? REG_RX_SIGNAL : REG_SIGNATURE;
            end
            data = $random(seed);
            old_value = expected_value(rd_index);
            fork
                axil_write(wr_index, data);
                axil_read(rd_index, got);
            join
            if (rd_index == wr_index) begin
                if (got !== old_value && got !== data) begin
                    errors++;
                    $display("mismatch rdata: got 0x%08h expected 0x%08h or 0x%08h",
                             got, old_value, data);
                end
            end else begin
                check_value("rdata", got, old_value);
            end
            check_read(wr_index);
        end
    endtask

    task automatic reset_and_latency();
        int cycles;
        axil_write(REG_RX_CTRL, $random(seed));
        // scratch write response is still pending when reset hits
        @(posedge clk);
        bready <= 1'b0;
        axil_write(REG_SCRATCH, $random(seed));
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        bready <= 1'b1;
        scratch_exp = 32'd0;
        rx_ctrl_exp = 32'd0;
        @(negedge clk);
        check_idle_outputs();
        check_read(REG_SCRATCH);
        check_read(REG_RX_CTRL);
        // count falling edges from arready to rvalid on a free bus
        @(posedge clk);
        araddr <= byte_addr(REG_SIGNATURE);
        arvalid <= 1'b1;
        wait_signal(SIG_ARREADY, "arready");
        @(posedge clk);
        arvalid <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!rvalid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rvalid) begin
            errors++;
            $display("timeout: rvalid did not go high after a single read");
        end else begin
            check_value("rvalid latency", 32'(cycles), 32'd4);
            check_value("rdata", rdata, RX_SIGNATURE);
        end
    endtask

    initial begin
        reset_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hf;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        fs_state = 2'd0;
        rx_signal = 32'd0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_idle_outputs();
        read_constant_registers();
        read_status_registers();
        write_writable_registers();
        back_pressure();
        concurrent_access();
        reset_and_latency();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/receiver_regmap_top.sv */
`timescale 1ns/10ps
`default_nettype none

module receiver_regmap_top #(
    parameter logic [31:0] ID = 32'd0,
    parameter int ADDRESS_WIDTH = 11
) (
    input  wire logic                     clk_i,
    input  wire logic                     reset_ni,

    // AXI-lite slave
    input  wire logic [ADDRESS_WIDTH-1:0] s_axi_awaddr_i,
    input  wire logic                     s_axi_awvalid_i,
    output logic                          s_axi_awready_o,
    input  wire logic [31:0]              s_axi_wdata_i,
    input  wire logic [3:0]               s_axi_wstrb_i,
    input  wire logic                     s_axi_wvalid_i,
    output logic                          s_axi_wready_o,
    output logic [1:0]                    s_axi_bresp_o,
    output logic                          s_axi_bvalid_o,
    input  wire logic                     s_axi_bready_i,
    input  wire logic [ADDRESS_WIDTH-1:0] s_axi_araddr_i,
    input  wire logic                     s_axi_arvalid_i,
    output logic                          s_axi_arready_o,
    output logic [31:0]                   s_axi_rdata_o,
    output logic [1:0]                    s_axi_rresp_o,
    output logic                          s_axi_rvalid_o,
    input  wire logic                     s_axi_rready_i,

    // receiver side
    input  wire logic [1:0]               fs_state_i,
    input  wire logic [31:0]              rx_signal_i,
    output logic [31:0]                   rx_ctrl_o
);

    import regmap_pkg::*;

    // front end to arbiter
    logic wr_req;
    regbus_req_t wr_bus;
    regbus_rsp_t wr_rsp;
    logic rd_req;
    regbus_req_t rd_bus;
    regbus_rsp_t rd_rsp;

    // arbiter to register map
    logic map_req;
    regbus_req_t map_bus;
    regbus_rsp_t map_rsp;

    axil_write_channel #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) i_write_channel (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .awaddr_i(s_axi_awaddr_i),
        .awvalid_i(s_axi_awvalid_i),
        .awready_o(s_axi_awready_o),
        .wdata_i(s_axi_wdata_i),
        .wstrb_i(s_axi_wstrb_i),
        .wvalid_i(s_axi_wvalid_i),
        .wready_o(s_axi_wready_o),
        .bresp_o(s_axi_bresp_o),
        .bvalid_o(s_axi_bvalid_o),
        .bready_i(s_axi_bready_i),
        .bus_req_o(wr_req),
        .bus_o(wr_bus),
        .bus_rsp_i(wr_rsp)
    );

    axil_read_channel #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) i_read_channel (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .araddr_i(s_axi_araddr_i),
        .arvalid_i(s_axi_arvalid_i),
        .arready_o(s_axi_arready_o),
        .rdata_o(s_axi_rdata_o),
        .rresp_o(s_axi_rresp_o),
        .rvalid_o(s_axi_rvalid_o),
        .rready_i(s_axi_rready_i),
        .bus_req_o(rd_req),
        .bus_o(rd_bus),
        .bus_rsp_i(rd_rsp)
    );

    regbus_arbiter i_arbiter (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .wr_req_i(wr_req),
        .wr_bus_i(wr_bus),
        .wr_rsp_o(wr_rsp),
        .rd_req_i(rd_req),
        .rd_bus_i(rd_bus),
        .rd_rsp_o(rd_rsp),
        .map_req_o(map_req),
        .map_bus_o(map_bus),
        .map_rsp_i(map_rsp)
    );

    receiver_regmap #(
        .ID(ID)
    ) i_regmap (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .req_i(map_req),
        .bus_i(map_bus),
        .rsp_o(map_rsp),
        .fs_state_i(fs_state_i),
        .rx_signal_i(rx_signal_i),
        .rx_ctrl_o(rx_ctrl_o)
    );

endmodule

`default_nettype wire

/* hdl/receiver_regmap.sv */
`timescale 1ns/10ps
`default_nettype none

module receiver_regmap #(
    parameter logic [31:0] ID = 32'd0
) (
    input  wire logic                     clk_i,
    input  wire logic                     reset_ni,

    // register bus, req_i is a single cycle strobe
    input  wire logic                     req_i,
    input  wire regmap_pkg::regbus_req_t  bus_i,
    output regmap_pkg::regbus_rsp_t       rsp_o,

    // receiver status
    input  wire logic [1:0]               fs_state_i,
    input  wire logic [31:0]              rx_signal_i,

    // receiver control
    output logic [31:0]                   rx_ctrl_o
);

    import regmap_pkg::*;

    logic ack_q;
    logic [31:0] rdata_q;
    logic [31:0] scratch_q;
    logic [31:0] rx_ctrl_q;

    // ack follows every strobe by one cycle, reads and writes alike
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i;
        end
    end

    // read mux, registered so rdata lines up with ack
    always_ff @(posedge clk_i) begin
        if (req_i && !bus_i.we) begin
            case (bus_i.index)
                REG_VERSION: rdata_q <= PCORE_VERSION;
                REG_ID: rdata_q <= ID;
                REG_SCRATCH: rdata_q <= scratch_q;
                REG_SIGNATURE: rdata_q <= RX_SIGNATURE;
                REG_PATTERN: rdata_q <= RX_PATTERN;
                // frame sync state is two bits, zero extended
                REG_FS_STATE: rdata_q <= {30'd0, fs_state_i};
                REG_RX_SIGNAL: rdata_q <= rx_signal_i;
                REG_RX_CTRL: rdata_q <= rx_ctrl_q;
                // unmapped indices read as zero
                default: rdata_q <= 32'd0;
            endcase
        end
    end

    // only scratch and rx control are writable
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            scratch_q <= 32'd0;
            rx_ctrl_q <= 32'd0;
        end else if (req_i && bus_i.we) begin
            case (bus_i.index)
                REG_SCRATCH: scratch_q <= bus_i.wdata;
                REG_RX_CTRL: rx_ctrl_q <= bus_i.wdata;
                // read-only and unmapped indices drop the write
                default: begin
                end
            endcase
        end
    end

    assign rsp_o = '{ack: ack_q, rdata: rdata_q};
    assign rx_ctrl_o = rx_ctrl_q;

endmodule

`default_nettype wire

/* hdl/regbus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module regbus_arbiter (
    input  wire logic                     clk_i,
    input  wire logic                     reset_ni,

    // write front end
    input  wire logic                     wr_req_i,
    input  wire regmap_pkg::regbus_req_t  wr_bus_i,
    output regmap_pkg::regbus_rsp_t       wr_rsp_o,

    // read front end
    input  wire logic                     rd_req_i,
    input  wire regmap_pkg::regbus_req_t  rd_bus_i,
    output regmap_pkg::regbus_rsp_t       rd_rsp_o,

    // register map
    output logic                          map_req_o,
    output regmap_pkg::regbus_req_t       map_bus_o,
    input  wire regmap_pkg::regbus_rsp_t  map_rsp_i
);

    import regmap_pkg::*;

    typedef enum logic {
        OWN_WR,
        OWN_RD
    } owner_e;

    logic busy_q;
    // owner of the access in flight, last winner once the bus is idle
    owner_e owner_q;
    logic wr_elig;
    logic rd_elig;
    logic bus_free;
    logic grant;
    owner_e winner;

    // the owner's request is still high in its ack cycle, so it is masked
    assign wr_elig = wr_req_i && !(busy_q && owner_q == OWN_WR);
    assign rd_elig = rd_req_i && !(busy_q && owner_q == OWN_RD);

    // a new grant may go out on the edge that completes the current access
    assign bus_free = !busy_q || map_rsp_i.ack;

    always_comb begin
        grant = 1'b0;
        winner = owner_q;
        if (bus_free) begin
            if (wr_elig && rd_elig) begin
                // both pending, the side not granted last time goes first
                grant = 1'b1;
                winner = (owner_q == OWN_WR) ? OWN_RD : OWN_WR;
            end else if (wr_elig) begin
                grant = 1'b1;
                winner = OWN_WR;
            end else if (rd_elig) begin
                grant = 1'b1;
                winner = OWN_RD;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q <= 1'b0;
            // write goes first after reset
            owner_q <= OWN_RD;
            map_req_o <= 1'b0;
        end else begin
            // single cycle strobe per grant
            map_req_o <= grant;
            if (grant) begin
                busy_q <= 1'b1;
                owner_q <= winner;
            end else if (map_rsp_i.ack) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) begin
            map_bus_o <= (winner == OWN_WR) ? wr_bus_i : rd_bus_i;
        end
    end

    // ack only reaches the owner, rdata is shared
    assign wr_rsp_o = '{ack: map_rsp_i.ack && owner_q == OWN_WR, rdata: map_rsp_i.rdata};
    assign rd_rsp_o = '{ack: map_rsp_i.ack && owner_q == OWN_RD, rdata: map_rsp_i.rdata};

endmodule

`default_nettype wire

/* hdl/axil_read_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_read_channel #(
    parameter int ADDRESS_WIDTH = 11
) (
    input  wire logic                     clk_i,
    input  wire logic                     reset_ni,

    // read address channel
    input  wire logic [ADDRESS_WIDTH-1:0] araddr_i,
    input  wire logic                     arvalid_i,
    output logic                          arready_o,

    // read data channel
    output logic [31:0]                   rdata_o,
    output logic [1:0]                    rresp_o,
    output logic                          rvalid_o,
    input  wire logic                     rready_i,

    // register bus side
    output logic                          bus_req_o,
    output regmap_pkg::regbus_req_t       bus_o,
    input  wire regmap_pkg::regbus_rsp_t  bus_rsp_i
);

    import regmap_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } state_e;

    state_e state_q;
    logic accept_q;
    logic [REG_INDEX_W-1:0] index_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= ST_IDLE;
            accept_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // idle implies rvalid is low
                    if (accept_q) begin
                        accept_q <= 1'b0;
                        state_q <= ST_BUS;
                    end else if (arvalid_i) begin
                        accept_q <= 1'b1;
                    end
                end
                ST_BUS: begin
                    if (bus_rsp_i.ack) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // address on acceptance, read data at ack, rdata holds through back-pressure
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && accept_q) begin
            index_q <= araddr_i[REG_INDEX_W+1:2];
        end
        if (state_q == ST_BUS && bus_rsp_i.ack) begin
            rdata_o <= bus_rsp_i.rdata;
        end
    end

    assign arready_o = accept_q;

    assign bus_req_o = (state_q == ST_BUS);
    assign bus_o = '{we: 1'b0, index: index_q, wdata: 32'd0};

    assign rvalid_o = (state_q == ST_RESP);
    // always OKAY
    assign rresp_o = 2'b00;

endmodule

`default_nettype wire

/* hdl/axil_write_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module axil_write_channel #(
    parameter int ADDRESS_WIDTH = 11
) (
    input  wire logic                     clk_i,
    input  wire logic                     reset_ni,

    // write address channel
    input  wire logic [ADDRESS_WIDTH-1:0] awaddr_i,
    input  wire logic                     awvalid_i,
    output logic                          awready_o,

    // write data channel
    input  wire logic [31:0]              wdata_i,
    // byte strobes are not supported, every write stores a full word
    input  wire logic [3:0]               wstrb_i,
    input  wire logic                     wvalid_i,
    output logic                          wready_o,

    // write response channel
    output logic [1:0]                    bresp_o,
    output logic                          bvalid_o,
    input  wire logic                     bready_i,

    // register bus side
    output logic                          bus_req_o,
    output regmap_pkg::regbus_req_t       bus_o,
    input  wire regmap_pkg::regbus_rsp_t  bus_rsp_i
);

    import regmap_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } state_e;

    state_e state_q;
    // shared ready pulse for address and data
    logic accept_q;
    logic [REG_INDEX_W-1:0] index_q;
    logic [31:0] wdata_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= ST_IDLE;
            accept_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept_q) begin
                        // both valids are still high, transfer happens here
                        accept_q <= 1'b0;
                        state_q <= ST_BUS;
                    end else if (awvalid_i && wvalid_i) begin
                        accept_q <= 1'b1;
                    end
                end
                ST_BUS: begin
                    // hold the request level until the arbiter routes the ack back
                    if (bus_rsp_i.ack) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // back-pressure, nothing new is accepted until bready
                    if (bready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // latch index and data on the accepting edge
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && accept_q) begin
            index_q <= awaddr_i[REG_INDEX_W+1:2];
            wdata_q <= wdata_i;
        end
    end

    assign awready_o = accept_q;
    assign wready_o = accept_q;

    assign bus_req_o = (state_q == ST_BUS);
    assign bus_o = '{we: 1'b1, index: index_q, wdata: wdata_q};

    assign bvalid_o = (state_q == ST_RESP);
    // always OKAY
    assign bresp_o = 2'b00;

endmodule

`default_nettype wire

/* hdl/regmap_pkg.sv */
`default_nettype none

package regmap_pkg;

    // width of the register word index, byte address bits [10:2]
    localparam int REG_INDEX_W = 9;

    // fixed register contents
    localparam logic [31:0] PCORE_VERSION = 32'h0004_0069;
    // ascii "RX~~"
    localparam logic [31:0] RX_SIGNATURE = 32'h5258_7E7E;
    localparam logic [31:0] RX_PATTERN = 32'h6969_6969;

    // one access on the internal register bus
    typedef struct packed {
        // high for a write, low for a read
        logic we;
        // word index into the register map
        logic [REG_INDEX_W-1:0] index;
        // write data, ignored on reads
        logic [31:0] wdata;
    } regbus_req_t;

    // completion of one register bus access
    typedef struct packed {
        // single cycle, one cycle after the request strobe
        logic ack;
        // read data, valid together with ack
        logic [31:0] rdata;
    } regbus_rsp_t;

    // receiver register map by word index
    typedef enum logic [REG_INDEX_W-1:0] {
        REG_VERSION = 9'd0,
        REG_ID = 9'd1,
        REG_SCRATCH = 9'd2,
        REG_SIGNATURE = 9'd3,
        REG_PATTERN = 9'd4,
        REG_FS_STATE = 9'd5,
        REG_RX_SIGNAL = 9'd6,
        REG_RX_CTRL = 9'd7
    } reg_index_e;

endpackage

`default_nettype wire
